// File: hdl/usb_rx_pkg.sv
// USB receive path definitions

package usb_rx_pkg;

	// Bit timing, four tb_clk cycles per full-speed bit
	localparam int clks_per_bit = 4;
	localparam int sample_phase = 2;

	// Bit stuffing limit
	localparam int max_ones = 6;

	// SYNC after NRZI decoding, LSB first
	localparam logic [7:0] sync_byte = 8'h80;

	// CRC16 generator and the remainder of a good packet
	localparam logic [15:0] crc16_poly = 16'h8005;
	localparam logic [15:0] crc16_residual = 16'h800D;

	// DATA PIDs with their check nibble
	localparam logic [7:0] pid_data0 = 8'hC3;
	localparam logic [7:0] pid_data1 = 8'h4B;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] crc16_t;
	typedef logic [2:0] bit_cnt_t;

	// One sample of the bus per bit period
	typedef struct packed {
		logic bit_valid;
		logic level;	// 1 for J, 0 for K
		logic se0;
	} line_sample_t;

	// Receive controller states
	typedef enum logic [2:0] {
		idle,
		sync,
		pid,
		data,
		wait_eop,
		error
	} rx_state_t;

endpackage

// File: hdl/usb_line_sampler.sv
// USB line sampler

`timescale 1ns/10ps

module usb_line_sampler (
	input  logic                     tb_clk,
	input  logic                     rst,
	input  logic                     d_plus,
	input  logic                     d_minus,
	output usb_rx_pkg::line_sample_t line,
	output logic                     eop_detect
);

	logic       dp_meta;
	logic       dp_sync;
	logic       dm_meta;
	logic       dm_sync;
	logic       is_j;
	logic       is_k;
	logic       is_se0;
	logic       last_level;
	logic       cur_level;
	logic       edge_seen;
	logic [1:0] phase_cnt;
	logic [1:0] phase_next;
	logic [2:0] se0_cnt;

	// Line state after the synchronizer
	assign is_j = dp_sync && !dm_sync;
	assign is_k = !dp_sync && dm_sync;
	assign is_se0 = !dp_sync && !dm_sync;

	// Hold the last J/K value through SE0 and SE1
	assign cur_level = (is_j || is_k) ? is_j : last_level;
	assign edge_seen = (is_j && !last_level) || (is_k && last_level);

	// Phase restarts on every J/K transition
	always_comb
	begin
		if (edge_seen || phase_cnt == 2'(usb_rx_pkg::clks_per_bit - 1))
			phase_next = 2'd0;
		else
			phase_next = phase_cnt + 2'd1;
	end

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			dp_meta <= 1'b1;
			dp_sync <= 1'b1;
			dm_meta <= 1'b0;
			dm_sync <= 1'b0;
			last_level <= 1'b1;
			phase_cnt <= 2'd0;
			se0_cnt <= 3'd0;
			line <= '{bit_valid: 1'b0, level: 1'b1, se0: 1'b0};
			eop_detect <= 1'b0;
		end
		else
		begin
			dp_meta <= d_plus;
			dp_sync <= dp_meta;
			dm_meta <= d_minus;
			dm_sync <= dm_meta;
			phase_cnt <= phase_next;
			last_level <= cur_level;
			line.bit_valid <= (phase_next == 2'(usb_rx_pkg::sample_phase));
			line.level <= cur_level;
			line.se0 <= is_se0;

			// End of packet is a full bit of SE0 and then J
			eop_detect <= is_j && (se0_cnt == 3'(usb_rx_pkg::clks_per_bit));
			if (is_se0)
			begin
				if (se0_cnt != 3'(usb_rx_pkg::clks_per_bit))
					se0_cnt <= se0_cnt + 3'd1;
			end
			else
				se0_cnt <= 3'd0;
		end
	end

endmodule

// File: hdl/usb_bit_decoder.sv
// NRZI decoder and bit unstuffer

`timescale 1ns/10ps

module usb_bit_decoder (
	input  logic                     tb_clk,
	input  logic                     rst,
	input  usb_rx_pkg::line_sample_t line,
	output logic                     data_bit,
	output logic                     data_valid,
	output logic                     stuff_err
);

	logic       prev_level;
	logic [2:0] ones_cnt;
	logic       same_level;

	// No change on the line means a one
	assign same_level = (line.level == prev_level);

	always_ff @(posedge tb_clk)
	begin
		if (line.bit_valid)
			data_bit <= same_level;
	end

	// ones_cnt above max_ones marks the idle line, so no zero is dropped there
	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			prev_level <= 1'b1;
			ones_cnt <= 3'(usb_rx_pkg::max_ones + 1);
			data_valid <= 1'b0;
			stuff_err <= 1'b0;
		end
		else
		begin
			data_valid <= 1'b0;
			stuff_err <= 1'b0;
			if (line.bit_valid)
			begin
				if (line.se0)
				begin
					// Back to idle J after the packet
					prev_level <= 1'b1;
					ones_cnt <= 3'(usb_rx_pkg::max_ones + 1);
				end
				else if (same_level)
				begin
					data_valid <= 1'b1;
					if (ones_cnt == 3'(usb_rx_pkg::max_ones))
					begin
						// Seventh one where a stuffed zero belongs
						stuff_err <= 1'b1;
						ones_cnt <= ones_cnt + 3'd1;
					end
					else if (ones_cnt < 3'(usb_rx_pkg::max_ones))
						ones_cnt <= ones_cnt + 3'd1;
				end
				else
				begin
					prev_level <= line.level;
					ones_cnt <= 3'd0;
					// Zero after six ones is the stuffed bit
					if (ones_cnt != 3'(usb_rx_pkg::max_ones))
						data_valid <= 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/usb_crc16_check.sv
// Serial CRC16 checker

`timescale 1ns/10ps

module usb_crc16_check (
	input  logic tb_clk,
	input  logic rst,
	input  logic crc_clear,
	input  logic crc_enable,
	input  logic data_bit,
	input  logic data_valid,
	output logic crc_ok
);

	usb_rx_pkg::crc16_t crc_q;
	logic               feedback;

	// Data enters LSB first against the register MSB
	assign feedback = data_bit ^ crc_q[15];

	always_ff @(posedge tb_clk)
	begin
		if (rst || crc_clear)
			crc_q <= '1;
		else if (crc_enable && data_valid)
		begin
			if (feedback)
				crc_q <= {crc_q[14:0], 1'b0} ^ usb_rx_pkg::crc16_poly;
			else
				crc_q <= {crc_q[14:0], 1'b0};
		end
	end

	// Good packet including its CRC field leaves the fixed residual
	assign crc_ok = (crc_q == usb_rx_pkg::crc16_residual);

endmodule

// File: hdl/usb_rx_control.sv
// USB receive controller

`timescale 1ns/10ps

module usb_rx_control (
	input  logic                     tb_clk,
	input  logic                     rst,
	input  logic                     data_bit,
	input  logic                     data_valid,
	input  logic                     stuff_err,
	input  logic                     eop_detect,
	input  logic                     crc_ok,
	input  usb_rx_pkg::line_sample_t line,
	output usb_rx_pkg::byte_t        rx_data,
	output logic                     write_enable,
	output logic                     eop,
	output logic                     rcv_error,
	output logic                     crc_clear,
	output logic                     crc_enable
);

	usb_rx_pkg::rx_state_t state_q;
	usb_rx_pkg::bit_cnt_t  bit_cnt_q;
	usb_rx_pkg::byte_t     next_byte;
	logic [6:0]            shift_q;
	logic                  data_pid_q;
	logic                  frame_err_q;
	logic                  byte_done;
	logic                  active;

	// Completed byte, the newest bit is the MSB
	assign next_byte = {data_bit, shift_q};
	assign byte_done = data_valid && (bit_cnt_q == 3'd7);

	assign active = (state_q == usb_rx_pkg::sync) ||
		(state_q == usb_rx_pkg::pid) ||
		(state_q == usb_rx_pkg::data);

	// CRC runs only over the payload of DATA packets
	assign crc_enable = (state_q == usb_rx_pkg::data) && data_pid_q;

	always_ff @(posedge tb_clk)
	begin
		if (data_valid)
			shift_q <= {data_bit, shift_q[6:1]};
	end

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			state_q <= usb_rx_pkg::idle;
			bit_cnt_q <= 3'd0;
			data_pid_q <= 1'b0;
			frame_err_q <= 1'b0;
			rx_data <= '0;
			write_enable <= 1'b0;
			eop <= 1'b0;
			rcv_error <= 1'b0;
			crc_clear <= 1'b0;
		end
		else
		begin
			write_enable <= 1'b0;
			crc_clear <= 1'b0;
			eop <= eop_detect;

			if (active && data_valid)
				bit_cnt_q <= bit_cnt_q + 3'd1;

			case (state_q)
				usb_rx_pkg::idle:
				begin
					// First K on the idle line opens SYNC
					if (line.bit_valid && !line.se0 && !line.level)
					begin
						state_q <= usb_rx_pkg::sync;
						bit_cnt_q <= 3'd0;
						data_pid_q <= 1'b0;
						frame_err_q <= 1'b0;
						crc_clear <= 1'b1;
						rcv_error <= 1'b0;
					end
				end
				usb_rx_pkg::sync:
				begin
					if (byte_done)
					begin
						if (next_byte == usb_rx_pkg::sync_byte)
							state_q <= usb_rx_pkg::pid;
						else
						begin
							state_q <= usb_rx_pkg::error;
							rcv_error <= 1'b1;
						end
					end
				end
				usb_rx_pkg::pid:
				begin
					if (byte_done)
					begin
						rx_data <= next_byte;
						write_enable <= 1'b1;
						data_pid_q <= (next_byte == usb_rx_pkg::pid_data0) ||
							(next_byte == usb_rx_pkg::pid_data1);
						state_q <= usb_rx_pkg::data;
					end
				end
				usb_rx_pkg::data:
				begin
					if (byte_done)
					begin
						rx_data <= next_byte;
						write_enable <= 1'b1;
					end
				end
				usb_rx_pkg::wait_eop:
				begin
					if (eop_detect)
					begin
						rcv_error <= frame_err_q || (data_pid_q && !crc_ok);
						state_q <= usb_rx_pkg::idle;
					end
				end
				usb_rx_pkg::error:
				begin
					// Drop the rest of the packet
					if (eop_detect)
						state_q <= usb_rx_pkg::idle;
				end
				default:
					state_q <= usb_rx_pkg::idle;
			endcase

			// Faults and SE0 take priority over byte handling
			if (active)
			begin
				if (stuff_err)
				begin
					state_q <= usb_rx_pkg::error;
					rcv_error <= 1'b1;
				end
				else if (line.bit_valid && line.se0)
				begin
					state_q <= usb_rx_pkg::wait_eop;
					// No PID yet, or a byte cut short
					frame_err_q <= (state_q != usb_rx_pkg::data) || (bit_cnt_q != 3'd0);
				end
			end
		end
	end

endmodule

// File: hdl/usb_rx_top.sv
// USB receive path top level

`timescale 1ns/10ps

module usb_rx_top (
	input  logic              tb_clk,
	input  logic              rst,
	input  logic              d_plus,
	input  logic              d_minus,
	output usb_rx_pkg::byte_t rx_data,
	output logic              write_enable,
	output logic              eop,
	output logic              rcv_error
);

	usb_rx_pkg::line_sample_t line;
	logic                     eop_detect;
	logic                     data_bit;
	logic                     data_valid;
	logic                     stuff_err;
	logic                     crc_clear;
	logic                     crc_enable;
	logic                     crc_ok;

	// Pair sampling and bit recovery
	usb_line_sampler u_sampler (
		.tb_clk     (tb_clk),
		.rst        (rst),
		.d_plus     (d_plus),
		.d_minus    (d_minus),
		.line       (line),
		.eop_detect (eop_detect)
	);

	usb_bit_decoder u_decoder (
		.tb_clk     (tb_clk),
		.rst        (rst),
		.line       (line),
		.data_bit   (data_bit),
		.data_valid (data_valid),
		.stuff_err  (stuff_err)
	);

	usb_crc16_check u_crc (
		.tb_clk     (tb_clk),
		.rst        (rst),
		.crc_clear  (crc_clear),
		.crc_enable (crc_enable),
		.data_bit   (data_bit),
		.data_valid (data_valid),
		.crc_ok     (crc_ok)
	);

	// Packet framing and byte output
	usb_rx_control u_control (
		.tb_clk       (tb_clk),
		.rst          (rst),
		.data_bit     (data_bit),
		.data_valid   (data_valid),
		.stuff_err    (stuff_err),
		.eop_detect   (eop_detect),
		.crc_ok       (crc_ok),
		.line         (line),
		.rx_data      (rx_data),
		.write_enable (write_enable),
		.eop          (eop),
		.rcv_error    (rcv_error),
		.crc_clear    (crc_clear),
		.crc_enable   (crc_enable)
	);

endmodule

// File: bench/tb_usb_rx_top.sv
// USB receive path testbench

`timescale 1ns/10ps

module tb_usb_rx_top;

	typedef enum logic [2:0] {
		fault_none,
		fault_crc,
		fault_sync,
		fault_ones,
		fault_trunc
	} fault_t;

	// One packet of the stimulus table
	typedef struct packed {
		usb_rx_pkg::byte_t pid;
		logic [3:0]        len;
		logic              rand_src;
		usb_rx_pkg::byte_t fill;
		usb_rx_pkg::byte_t step;
		fault_t            fault;
	} stim_row_t;

	localparam int num_rows = 11;
	localparam int bit_time = usb_rx_pkg::clks_per_bit;
	// Reset, idle check and 200 bit times per row
	localparam int watchdog_cycles = 16 + 16 * bit_time + num_rows * 200 * bit_time;

	logic              tb_clk = 1'b0;
	logic              rst;
	logic              d_plus;
	logic              d_minus;
	usb_rx_pkg::byte_t rx_data;
	logic              write_enable;
	logic              eop;
	logic              rcv_error;

	stim_row_t         stim [0:num_rows-1];
	usb_rx_pkg::byte_t exp_bytes [$];
	usb_rx_pkg::byte_t got_bytes [$];
	usb_rx_pkg::byte_t pkt_bytes [0:15];
	int                pkt_len;
	logic              line_bits [0:255];
	int                line_len;
	int                ones_run;
	int                eop_count;
	logic [31:0]       rng_state;

	usb_rx_top dut (
		.tb_clk       (tb_clk),
		.rst          (rst),
		.d_plus       (d_plus),
		.d_minus      (d_minus),
		.rx_data      (rx_data),
		.write_enable (write_enable),
		.eop          (eop),
		.rcv_error    (rcv_error)
	);

	always #10 tb_clk = ~tb_clk;

	// Byte and end of packet collector
	always @(negedge tb_clk)
	begin
		if (write_enable)
			got_bytes.push_back(rx_data);
		if (eop)
			eop_count = eop_count + 1;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge tb_clk);
		abort_run("Watchdog timeout, the receiver stopped making progress");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// USB CRC16 in reflected form, bytes taken LSB first
	function automatic logic [15:0] crc16_usb(input int first, input int last);
		logic [15:0] crc;
		crc = 16'hFFFF;
		for (int i = first; i < last; i++)
		begin
			for (int j = 0; j < 8; j++)
			begin
				if (crc[0] ^ pkt_bytes[i][j])
					crc = (crc >> 1) ^ 16'hA001;
				else
					crc = crc >> 1;
			end
		end
		return crc;
	endfunction

	function automatic stim_row_t make_row(input usb_rx_pkg::byte_t pid, input int len,
		input logic rand_src, input usb_rx_pkg::byte_t fill,
		input usb_rx_pkg::byte_t step, input fault_t fault);
		stim_row_t r;
		r.pid = pid;
		r.len = 4'(len);
		r.rand_src = rand_src;
		r.fill = fill;
		r.step = step;
		r.fault = fault;
		return r;
	endfunction

	task automatic fill_stim();
		stim[0] = make_row(usb_rx_pkg::pid_data0, 4, 1'b0, 8'h10, 8'h11, fault_none);
		// Runs of ones force stuffed bits
		stim[1] = make_row(usb_rx_pkg::pid_data1, 6, 1'b0, 8'hFF, 8'h00, fault_none);
		stim[2] = make_row(usb_rx_pkg::pid_data0, 5, 1'b1, 8'h00, 8'h00, fault_crc);
		stim[3] = make_row(usb_rx_pkg::pid_data1, 2, 1'b0, 8'hA5, 8'h01, fault_sync);
		stim[4] = make_row(usb_rx_pkg::pid_data0, 3, 1'b0, 8'h01, 8'h02, fault_none);
		stim[5] = make_row(usb_rx_pkg::pid_data0, 2, 1'b0, 8'h3C, 8'h00, fault_ones);
		stim[6] = make_row(usb_rx_pkg::pid_data1, 3, 1'b1, 8'h00, 8'h00, fault_none);
		stim[7] = make_row(usb_rx_pkg::pid_data0, 3, 1'b0, 8'h77, 8'h01, fault_trunc);
		// ACK handshake, PID only
		stim[8] = make_row(8'hD2, 0, 1'b0, 8'h00, 8'h00, fault_none);
		stim[9] = make_row(usb_rx_pkg::pid_data1, 0, 1'b0, 8'h00, 8'h00, fault_none);
		stim[10] = make_row(usb_rx_pkg::pid_data0, 8, 1'b1, 8'h00, 8'h00, fault_none);
	endtask

	task automatic put_line_bit(input logic b);
		line_bits[line_len] = b;
		line_len = line_len + 1;
	endtask

	task automatic push_data_bit(input logic b);
		put_line_bit(b);
		if (b)
			ones_run = ones_run + 1;
		else
			ones_run = 0;
		// Six ones are followed by a stuffed zero
		if (ones_run == 6)
		begin
			put_line_bit(1'b0);
			ones_run = 0;
		end
	endtask

	task automatic push_byte(input usb_rx_pkg::byte_t b);
		for (int j = 0; j < 8; j++)
			push_data_bit(b[j]);
	endtask

	task automatic drive_state(input logic dp, input logic dm);
		@(posedge tb_clk);
		#2;
		d_plus = dp;
		d_minus = dm;
		repeat (bit_time - 1) @(posedge tb_clk);
	endtask

	task automatic send_packet(input stim_row_t r);
		usb_rx_pkg::byte_t sync_val;
		logic [15:0]       crc;
		logic              level;
		int                n_send;
		exp_bytes.delete();
		got_bytes.delete();
		eop_count = 0;
		line_len = 0;
		ones_run = 0;

		pkt_bytes[0] = r.pid;
		pkt_len = 1;
		for (int i = 0; i < r.len; i++)
		begin
			if (r.rand_src)
			begin
				rng_state = xorshift(rng_state);
				pkt_bytes[pkt_len] = rng_state[7:0];
			end
			else
				pkt_bytes[pkt_len] = r.fill + usb_rx_pkg::byte_t'(i) * r.step;
			pkt_len = pkt_len + 1;
		end
		if (r.pid == usb_rx_pkg::pid_data0 || r.pid == usb_rx_pkg::pid_data1)
		begin
			crc = ~crc16_usb(1, pkt_len);
			pkt_bytes[pkt_len] = crc[7:0];
			pkt_bytes[pkt_len + 1] = crc[15:8];
			if (r.fault == fault_crc)
				pkt_bytes[pkt_len][0] = ~pkt_bytes[pkt_len][0];
			pkt_len = pkt_len + 2;
		end

		// A bad SYNC still opens with K
		sync_val = (r.fault == fault_sync) ? 8'h40 : usb_rx_pkg::sync_byte;
		push_byte(sync_val);
		n_send = (r.fault == fault_ones) ? 1 : pkt_len;
		for (int i = 0; i < n_send; i++)
			push_byte(pkt_bytes[i]);
		// Unstuffed run up to the seventh one
		if (r.fault == fault_ones)
		begin
			while (ones_run < 7)
			begin
				put_line_bit(1'b1);
				ones_run = ones_run + 1;
			end
		end
		if (r.fault == fault_trunc)
		begin
			push_data_bit(1'b1);
			push_data_bit(1'b0);
			push_data_bit(1'b1);
		end

		if (r.fault == fault_ones)
			exp_bytes.push_back(pkt_bytes[0]);
		else if (r.fault != fault_sync)
		begin
			for (int i = 0; i < pkt_len; i++)
				exp_bytes.push_back(pkt_bytes[i]);
		end

		// NRZI from the idle J state
		level = 1'b1;
		for (int i = 0; i < line_len; i++)
		begin
			if (i == 8)
			begin
				// Old error flag is gone once SYNC has started
				@(negedge tb_clk);
				check_value("rcv_error at SYNC", rcv_error, 0);
			end
			if (!line_bits[i])
				level = ~level;
			drive_state(level, ~level);
		end
		// Two bits of SE0, then J
		drive_state(1'b0, 1'b0);
		drive_state(1'b0, 1'b0);
		drive_state(1'b1, 1'b0);
	endtask

	task automatic finish_packet(input stim_row_t r, input int row);
		int waited;
		waited = 0;
		while (eop_count == 0 && waited < 4 * bit_time)
		begin
			@(posedge tb_clk);
			waited = waited + 1;
		end
		if (eop_count == 0)
			abort_run($sformatf("Packet %0d ended without an eop pulse", row));
		// Idle gap where nothing more may arrive
		repeat (4 * bit_time) @(posedge tb_clk);
		#1;
		check_value("eop count", eop_count, 1);
		check_value("write_enable count", got_bytes.size(), exp_bytes.size());
		for (int i = 0; i < exp_bytes.size(); i++)
			check_value($sformatf("rx_data[%0d]", i), got_bytes[i], exp_bytes[i]);
		check_value("rcv_error", rcv_error, r.fault != fault_none);
	endtask

	initial
	begin
		rst = 1'b1;
		d_plus = 1'b1;
		d_minus = 1'b0;
		eop_count = 0;
		ones_run = 0;
		rng_state = 32'h7ae7;
		fill_stim();
		repeat (16) @(posedge tb_clk);
		#2;
		rst = 1'b0;

		// Quiet outputs on an idle J line
		repeat (16 * bit_time)
		begin
			@(negedge tb_clk);
			check_value("write_enable", write_enable, 0);
			check_value("eop", eop, 0);
			check_value("rcv_error", rcv_error, 0);
			check_value("rx_data", rx_data, 0);
		end

		for (int row = 0; row < num_rows; row++)
		begin
			send_packet(stim[row]);
			finish_packet(stim[row], row);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: usb_rx_top.f
hdl/usb_rx_pkg.sv
hdl/usb_line_sampler.sv
hdl/usb_bit_decoder.sv
hdl/usb_crc16_check.sv
hdl/usb_rx_control.sv
hdl/usb_rx_top.sv
bench/tb_usb_rx_top.sv

// File: Bender.yml
package:
  name: usb_rx

sources:
  - hdl/usb_rx_pkg.sv
  - hdl/usb_line_sampler.sv
  - hdl/usb_bit_decoder.sv
  - hdl/usb_crc16_check.sv
  - hdl/usb_rx_control.sv
  - hdl/usb_rx_top.sv
  - target: test
    files:
      - bench/tb_usb_rx_top.sv
